// File: Makefile
# Verilator build and run of the GPIO testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_gpio
FILELIST ?= gpio.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The log decides the result, so a crash without a verdict also fails
run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: gpio.f
rtl/gpio_pkg.sv
rtl/gpio_regs.sv
rtl/gpio_pad_mux.sv
rtl/gpio.sv
sim/tb_clk_gen.sv
sim/tb_gpio.sv

// File: rtl/gpio.sv
// GPIO top level with the APB register block feeding the pad mux.
// Pads leave as separate out, oe and in vectors; buffers live in the board wrapper.
`timescale 1ns/1ps

module gpio
	import gpio_pkg::*;
#(
	// Depth of the pad input synchronizer
	parameter int SYNC_STAGES = 2
) (
	input  logic        clk,
	input  logic        rst_n,

	// APB slave port
	input  apb_req_t    apb_req_i,
	output apb_rsp_t    apb_rsp_o,

	// Fixed peripherals
	input  periph_out_t periph_out_i,
	output periph_in_t  periph_in_o,

	// Pads
	input  pad_vec_t    pad_in_i,
	output pad_vec_t    pad_out_o,
	output pad_vec_t    pad_oe_o
);

	pad_vec_t out;
	pad_vec_t dir;
	pad_vec_t fsel;
	pad_vec_t in_sync;

	gpio_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req_i (apb_req_i),
		.apb_rsp_o (apb_rsp_o),
		.in_sync_i (in_sync),
		.out_o     (out),
		.dir_o     (dir),
		.fsel_o    (fsel)
	);

	gpio_pad_mux #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_pad_mux (
		.clk          (clk),
		.rst_n        (rst_n),
		.out_i        (out),
		.dir_i        (dir),
		.fsel_i       (fsel),
		.periph_out_i (periph_out_i),
		.periph_in_o  (periph_in_o),
		.pad_in_i     (pad_in_i),
		.pad_out_o    (pad_out_o),
		.pad_oe_o     (pad_oe_o),
		.in_sync_o    (in_sync)
	);

endmodule

// File: rtl/gpio_pad_mux.sv
// Pad side of the GPIO with per-pad output and enable select, input synchronizer
// and routing of pad inputs back to the UART and SPI.
`timescale 1ns/1ps

module gpio_pad_mux
	import gpio_pkg::*;
#(
	parameter int SYNC_STAGES = 2
) (
	input  logic        clk,
	input  logic        rst_n,

	input  pad_vec_t    out_i,
	input  pad_vec_t    dir_i,
	input  pad_vec_t    fsel_i,

	input  periph_out_t periph_out_i,
	output periph_in_t  periph_in_o,

	input  pad_vec_t    pad_in_i,
	output pad_vec_t    pad_out_o,
	output pad_vec_t    pad_oe_o,

	output pad_vec_t    in_sync_o
);

	// Pad assignment of the fixed peripherals
	localparam int PAD_LCD_PWM  = 5;
	localparam int PAD_SPI_CS   = 10;
	localparam int PAD_SPI_SCLK = 11;
	localparam int PAD_SPI_SDO  = 12;
	localparam int PAD_SPI_SDI  = 13;
	localparam int PAD_UART_RX  = 14;
	localparam int PAD_UART_TX  = 15;

	// Pads with a peripheral output are always driven under fsel
	localparam pad_vec_t PERIPH_OE = pad_vec_t'((1 << PAD_LCD_PWM) | (1 << PAD_SPI_CS) |
		(1 << PAD_SPI_SCLK) | (1 << PAD_SPI_SDO) | (1 << PAD_UART_TX));

	pad_vec_t periph_out;
	pad_vec_t sync_q [SYNC_STAGES];

	// Peripheral value seen by each pad when its fsel bit is set.
	// Pads with no peripheral output, including the SPI and UART inputs, stay low.
	always_comb begin
		periph_out = '0;

		periph_out[PAD_LCD_PWM]  = periph_out_i.lcd_pwm;
		periph_out[PAD_SPI_CS]   = periph_out_i.spi_cs;
		periph_out[PAD_SPI_SCLK] = periph_out_i.spi_sclk;
		periph_out[PAD_SPI_SDO]  = periph_out_i.spi_sdo;
		periph_out[PAD_UART_TX]  = periph_out_i.uart_tx;
	end

	// fsel 0 gives the pad to software, fsel 1 to the peripheral
	assign pad_out_o = (fsel_i & periph_out) | (~fsel_i & out_i);
	assign pad_oe_o  = (fsel_i & PERIPH_OE)  | (~fsel_i & dir_i);

	// Input synchronizer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= pad_in_i;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign in_sync_o = sync_q[SYNC_STAGES-1];

	// UART is happy with the synchronizer latency, SPI data-in is not
	assign periph_in_o = '{
		uart_rx: in_sync_o[PAD_UART_RX],
		spi_sdi: pad_in_i[PAD_SPI_SDI]
	};

	// Checks

	// SPI data-in pad must never be driven while handed to the peripheral
	assert property (@(posedge clk) disable iff (!rst_n)
		fsel_i[PAD_SPI_SDI] |-> !pad_oe_o[PAD_SPI_SDI])
	else $error("pad 13 output enabled under function select");

	// UART receive lags its pad by exactly the synchronizer depth
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n, SYNC_STAGES) |->
			(periph_in_o.uart_rx == $past(pad_in_i[PAD_UART_RX], SYNC_STAGES)))
	else $error("uart_rx latency mismatch");

endmodule

// File: rtl/gpio_pkg.sv
// Shared types, register offsets and bus structs for the GPIO block.
// Imported by every GPIO module and by the testbench.
package gpio_pkg;

	// Pad count is fixed by the per-pad peripheral table
	localparam int N_PADS = 16;

	typedef logic [N_PADS-1:0] pad_vec_t;
	typedef logic [15:0]       apb_addr_t;
	typedef logic [31:0]       apb_data_t;

	// Only the low 12 address bits are decoded here
	typedef logic [11:0]       reg_offs_t;

	localparam reg_offs_t ADDR_OUT     = 12'h000;
	localparam reg_offs_t ADDR_OUT_SET = 12'h004;
	localparam reg_offs_t ADDR_OUT_CLR = 12'h008;
	localparam reg_offs_t ADDR_OUT_XOR = 12'h00c;
	localparam reg_offs_t ADDR_DIR     = 12'h010;
	localparam reg_offs_t ADDR_IN      = 12'h014;
	localparam reg_offs_t ADDR_FSEL    = 12'h018;

	// APB request, driven by the bus master
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// APB response
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// Peripheral signals heading out to pads
	typedef struct packed {
		logic lcd_pwm;
		logic uart_tx;
		logic spi_sclk;
		logic spi_cs;
		logic spi_sdo;
	} periph_out_t;

	// Pad inputs handed back to peripherals
	typedef struct packed {
		logic uart_rx;
		logic spi_sdi;
	} periph_in_t;

endpackage

// File: rtl/gpio_regs.sv
// APB register block of the GPIO with OUT and its set, clear and toggle aliases, DIR, FSEL and IN.
// Zero wait states; bad offsets and writes to IN end with pslverr.
`timescale 1ns/1ps

module gpio_regs
	import gpio_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,

	input  pad_vec_t in_sync_i,
	output pad_vec_t out_o,
	output pad_vec_t dir_o,
	output pad_vec_t fsel_o
);

	reg_offs_t offs;
	pad_vec_t  wdata;

	logic access;
	logic wr_en;
	logic rd_en;

	logic hit_out;
	logic hit_set;
	logic hit_clr;
	logic hit_xor;
	logic hit_dir;
	logic hit_in;
	logic hit_fsel;
	logic mapped;
	logic illegal;

	logic out_wr;
	logic dir_wr;
	logic fsel_wr;

	pad_vec_t  out_q;
	pad_vec_t  dir_q;
	pad_vec_t  fsel_q;
	pad_vec_t  out_next;
	apb_data_t rdata;

	// Decode

	assign offs  = apb_req_i.paddr[11:0];
	assign wdata = apb_req_i.pwdata[N_PADS-1:0];

	// Slave is always ready, so every access cycle completes
	assign access = apb_req_i.psel && apb_req_i.penable;
	assign wr_en  = access && apb_req_i.pwrite;
	assign rd_en  = access && !apb_req_i.pwrite;

	assign hit_out  = (offs == ADDR_OUT);
	assign hit_set  = (offs == ADDR_OUT_SET);
	assign hit_clr  = (offs == ADDR_OUT_CLR);
	assign hit_xor  = (offs == ADDR_OUT_XOR);
	assign hit_dir  = (offs == ADDR_DIR);
	assign hit_in   = (offs == ADDR_IN);
	assign hit_fsel = (offs == ADDR_FSEL);

	assign mapped = hit_out || hit_set || hit_clr || hit_xor ||
		hit_dir || hit_in || hit_fsel;

	// IN is read only; a write there is rejected like an unmapped access
	assign illegal = !mapped || (apb_req_i.pwrite && hit_in);

	assign out_wr  = wr_en && !illegal && (hit_out || hit_set || hit_clr || hit_xor);
	assign dir_wr  = wr_en && !illegal && hit_dir;
	assign fsel_wr = wr_en && !illegal && hit_fsel;

	// New OUT value for a plain write or one of the atomic aliases
	always_comb begin
		out_next = out_q;
		if (hit_out) begin
			out_next = wdata;
		end else if (hit_set) begin
			out_next = out_q | wdata;
		end else if (hit_clr) begin
			out_next = out_q & ~wdata;
		end else if (hit_xor) begin
			out_next = out_q ^ wdata;
		end
	end

	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_q <= '0;
		end else if (out_wr) begin
			out_q <= out_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dir_q <= '0;
		end else if (dir_wr) begin
			dir_q <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fsel_q <= '0;
		end else if (fsel_wr) begin
			fsel_q <= wdata;
		end
	end

	assign out_o  = out_q;
	assign dir_o  = dir_q;
	assign fsel_o = fsel_q;

	// Read path, combinational in the access cycle

	always_comb begin
		rdata = '0;
		if (rd_en) begin
			case (offs)
				ADDR_OUT:  rdata = apb_data_t'(out_q);
				ADDR_DIR:  rdata = apb_data_t'(dir_q);
				ADDR_IN:   rdata = apb_data_t'(in_sync_i);
				ADDR_FSEL: rdata = apb_data_t'(fsel_q);
				// Alias offsets and unmapped space read as zero
				default:   rdata = '0;
			endcase
		end
	end

	assign apb_rsp_o = '{
		prdata:  rdata,
		pready:  1'b1,
		pslverr: access && illegal
	};

	// Checks

	// Error is only ever signalled during an access cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		apb_rsp_o.pslverr |-> (apb_req_i.psel && apb_req_i.penable))
	else $error("pslverr outside access cycle");

endmodule

// File: sim/tb_clk_gen.sv
// Clock and reset source for the GPIO testbench
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset released on a rising edge after RST_CYCLES cycles
	initial begin
		rst_n <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: sim/tb_gpio.sv
// Testbench for the GPIO block with APB tasks, a pad loopback model and a register model.
// Assertions compare the DUT with the model; run through the Makefile with Verilator.
`timescale 1ns/1ps

module tb_gpio
	import gpio_pkg::*;
();

	localparam int CLK_PERIOD    = 10;
	localparam int RST_CYCLES    = 4;
	localparam int N_OUT         = 32;
	localparam int N_DIR         = 8;
	localparam int N_FSEL        = 12;
	localparam int PERIPH_CYCLES = 6;
	localparam int ROUTE_CYCLES  = 24;
	localparam int N_BAD         = 5;

	// Transfers of all tests at about 3 cycles each
	localparam int XFERS = 3 + 2 * N_OUT + 3 * N_DIR + 4 * N_FSEL + 2 + 2 * N_BAD + 6;
	localparam int IDLE_CYCLES = RST_CYCLES + N_FSEL * PERIPH_CYCLES + ROUTE_CYCLES;
	localparam int WATCHDOG_NS = (3 * XFERS + IDLE_CYCLES + 50) * CLK_PERIOD;

	// Pads 5, 10, 11, 12 and 15 carry a peripheral output under fsel
	localparam pad_vec_t PERIPH_PADS = 16'h9c20;

	localparam reg_offs_t BAD_OFFS [N_BAD] = '{12'h01c, 12'h020, 12'h002, 12'h100, 12'hffc};

	logic        clk;
	logic        rst_n;
	apb_req_t    req;
	apb_rsp_t    rsp;
	periph_out_t periph_out;
	periph_in_t  periph_in;
	pad_vec_t    pad_in;
	pad_vec_t    pad_out;
	pad_vec_t    pad_oe;
	pad_vec_t    ext_in;

	// Pad 14 over the last two edges, oldest in bit 1
	logic [1:0]  pad14_hist;

	// Register model that updates on the edge ending each accepted write
	pad_vec_t out_m;
	pad_vec_t dir_m;
	pad_vec_t fsel_m;

	logic [31:0] lcg_state;
	string       cur_test;
	int          check_cnt;
	int          fail_cnt;
	int          test_cnt;
	int          test_fail_base;

	tb_clk_gen #(
		.PERIOD_NS  (CLK_PERIOD),
		.RST_CYCLES (RST_CYCLES)
	) u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	gpio #(
		.SYNC_STAGES (2)
	) DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.apb_req_i    (req),
		.apb_rsp_o    (rsp),
		.periph_out_i (periph_out),
		.periph_in_o  (periph_in),
		.pad_in_i     (pad_in),
		.pad_out_o    (pad_out),
		.pad_oe_o     (pad_oe)
	);

	// Driven pads loop back, undriven pads see the external value
	assign pad_in = (pad_oe & pad_out) | (~pad_oe & ext_in);

	always @(posedge clk) begin
		pad14_hist <= {pad14_hist[0], pad_in[14]};
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Low LCG bits repeat too soon, so only the upper half is used
	function automatic pad_vec_t rand16();
		logic [31:0] r;
		r = next_rand();
		return r[31:16];
	endfunction

	function automatic pad_vec_t exp_pad_out(pad_vec_t o, pad_vec_t f, periph_out_t p);
		pad_vec_t v;
		v = o & ~f;
		v[5]  = f[5]  ? p.lcd_pwm  : v[5];
		v[10] = f[10] ? p.spi_cs   : v[10];
		v[11] = f[11] ? p.spi_sclk : v[11];
		v[12] = f[12] ? p.spi_sdo  : v[12];
		v[15] = f[15] ? p.uart_tx  : v[15];
		return v;
	endfunction

	function automatic pad_vec_t exp_pad_oe(pad_vec_t d, pad_vec_t f);
		return (d & ~f) | (f & PERIPH_PADS);
	endfunction

	function automatic logic exp_err(logic wr, reg_offs_t offs);
		logic mapped;
		mapped = offs inside {ADDR_OUT, ADDR_OUT_SET, ADDR_OUT_CLR, ADDR_OUT_XOR,
			ADDR_DIR, ADDR_IN, ADDR_FSEL};
		return !mapped || (wr && offs == ADDR_IN);
	endfunction

	function automatic void record_fail(string what, apb_data_t exp, apb_data_t act);
		fail_cnt++;
		$display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
	endfunction

	function automatic void check_equal(string what, apb_data_t exp, apb_data_t act);
		check_cnt++;
		assert (act === exp) else record_fail(what, exp, act);
	endfunction

	function automatic void finish_test();
		test_cnt++;
		$display("test %-10s %s (%0d failures)", cur_test,
			(fail_cnt == test_fail_base) ? "ok" : "FAILED", fail_cnt - test_fail_base);
		test_fail_base = fail_cnt;
	endfunction

	task automatic model_write(input reg_offs_t offs, input apb_data_t data);
		case (offs)
			ADDR_OUT:     out_m  <= data[15:0];
			ADDR_OUT_SET: out_m  <= out_m | data[15:0];
			ADDR_OUT_CLR: out_m  <= out_m & ~data[15:0];
			ADDR_OUT_XOR: out_m  <= out_m ^ data[15:0];
			ADDR_DIR:     dir_m  <= data[15:0];
			ADDR_FSEL:    fsel_m <= data[15:0];
			default:      ;
		endcase
	endtask

	// One APB transfer with a setup cycle and then access until pready
	task automatic apb_xfer(input logic wr, input reg_offs_t offs, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		logic [31:0] r;
		r = next_rand();
		@(posedge clk);
		req.psel    <= 1'b1;
		req.penable <= 1'b0;
		req.pwrite  <= wr;
		// Upper address bits go to the system decoder and must not matter here
		req.paddr   <= {r[31:28], offs};
		req.pwdata  <= wdata;
		@(posedge clk);
		req.penable <= 1'b1;
		@(negedge clk);
		while (!rsp.pready) begin
			@(negedge clk);
		end
		rdata = rsp.prdata;
		err   = rsp.pslverr;
		@(posedge clk);
		req.psel    <= 1'b0;
		req.penable <= 1'b0;
		if (wr && !exp_err(wr, offs)) begin
			model_write(offs, wdata);
		end
		check_equal("pslverr", apb_data_t'(exp_err(wr, offs)), apb_data_t'(err));
	endtask

	task automatic apb_write(input reg_offs_t offs, input apb_data_t data, output logic err);
		apb_data_t unused_rd;
		apb_xfer(1'b1, offs, data, unused_rd, err);
	endtask

	task automatic apb_read(input reg_offs_t offs, output apb_data_t data, output logic err);
		apb_xfer(1'b0, offs, 32'h0, data, err);
	endtask

	// Pad outputs against the function select table
	assert property (@(posedge clk) disable iff (!rst_n)
		pad_out == exp_pad_out(out_m, fsel_m, periph_out))
	else record_fail("pad_out_o",
		apb_data_t'(exp_pad_out($sampled(out_m), $sampled(fsel_m), $sampled(periph_out))),
		apb_data_t'($sampled(pad_out)));

	assert property (@(posedge clk) disable iff (!rst_n)
		pad_oe == exp_pad_oe(dir_m, fsel_m))
	else record_fail("pad_oe_o", apb_data_t'(exp_pad_oe($sampled(dir_m), $sampled(fsel_m))),
		apb_data_t'($sampled(pad_oe)));

	// SPI data-in pad stays an input once handed to the peripheral
	assert property (@(posedge clk) disable iff (!rst_n)
		fsel_m[13] |-> !pad_oe[13])
	else record_fail("pad 13 oe", 32'h0, 32'h1);

	// UART receive lags pad 14 by the two synchronizer stages
	assert property (@(posedge clk) disable iff (!rst_n)
		periph_in.uart_rx == pad14_hist[1])
	else record_fail("uart_rx", apb_data_t'($sampled(pad14_hist[1])),
		apb_data_t'($sampled(periph_in.uart_rx)));

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired in test %s before the run completed", cur_test);
		$display("Regression failed");
		$finish;
	end

	initial begin
		apb_data_t r;
		apb_data_t d;
		apb_data_t rd;
		pad_vec_t  lvl;
		reg_offs_t offs;
		logic      err;

		req        <= '0;
		periph_out <= '0;
		ext_in     <= '0;
		out_m      <= '0;
		dir_m      <= '0;
		fsel_m     <= '0;
		lcg_state  = 32'h2bb0_6dd6;
		check_cnt  = 0;
		fail_cnt   = 0;
		test_cnt   = 0;
		test_fail_base = 0;
		cur_test   = "reset";

		wait (rst_n === 1'b1);

		@(negedge clk);
		check_equal("pad_oe_o", 32'h0, apb_data_t'(pad_oe));
		check_equal("pad_out_o", 32'h0, apb_data_t'(pad_out));
		apb_read(ADDR_OUT, rd, err);
		check_equal("OUT", 32'h0, rd);
		apb_read(ADDR_DIR, rd, err);
		check_equal("DIR", 32'h0, rd);
		apb_read(ADDR_FSEL, rd, err);
		check_equal("FSEL", 32'h0, rd);
		finish_test();

		cur_test = "out_alias";
		for (int i = 0; i < N_OUT; i++) begin
			r = next_rand();
			d = {rand16(), rand16()};
			case (r[31:30])
				2'd0:    offs = ADDR_OUT;
				2'd1:    offs = ADDR_OUT_SET;
				2'd2:    offs = ADDR_OUT_CLR;
				default: offs = ADDR_OUT_XOR;
			endcase
			apb_write(offs, d, err);
			apb_read(ADDR_OUT, rd, err);
			check_equal("OUT", apb_data_t'(out_m), rd);
		end
		finish_test();

		// FSEL is still zero, so every pad belongs to software
		cur_test = "direction";
		for (int i = 0; i < N_DIR; i++) begin
			apb_write(ADDR_DIR, {rand16(), rand16()}, err);
			apb_write(ADDR_OUT, {rand16(), rand16()}, err);
			ext_in <= rand16();
			apb_read(ADDR_IN, rd, err);
			lvl = (dir_m & out_m) | (~dir_m & ext_in);
			check_equal("IN", apb_data_t'(lvl), rd);
		end
		finish_test();

		cur_test = "fsel";
		for (int i = 0; i < N_FSEL; i++) begin
			d = {rand16(), rand16()};
			if (i % 2 == 0) begin
				d[13] = 1'b1;
			end
			apb_write(ADDR_FSEL, d, err);
			// DIR bit 13 set so that pad 13 would show a missing override
			apb_write(ADDR_DIR, {rand16(), rand16()} | 32'h2000, err);
			apb_write(ADDR_OUT, {rand16(), rand16()}, err);
			repeat (PERIPH_CYCLES) begin
				@(posedge clk);
				r = next_rand();
				periph_out <= r[31:27];
			end
			apb_read(ADDR_FSEL, rd, err);
			check_equal("FSEL", apb_data_t'(fsel_m), rd);
		end
		finish_test();

		// With all pads undriven pad_in follows ext_in
		cur_test = "routing";
		apb_write(ADDR_FSEL, 32'h0, err);
		apb_write(ADDR_DIR, 32'h0, err);
		repeat (ROUTE_CYCLES) begin
			ext_in <= rand16();
			@(negedge clk);
			check_equal("spi_sdi", apb_data_t'(ext_in[13]), apb_data_t'(periph_in.spi_sdi));
			@(posedge clk);
		end
		finish_test();

		cur_test = "errors";
		apb_write(ADDR_DIR, {rand16(), rand16()}, err);
		apb_write(ADDR_FSEL, {rand16(), rand16()}, err);
		for (int i = 0; i < N_BAD; i++) begin
			apb_write(BAD_OFFS[i], {rand16(), rand16()}, err);
			check_equal("write pslverr", 32'h1, apb_data_t'(err));
			apb_read(BAD_OFFS[i], rd, err);
			check_equal("read pslverr", 32'h1, apb_data_t'(err));
		end
		apb_write(ADDR_IN, 32'hffff_ffff, err);
		check_equal("IN write pslverr", 32'h1, apb_data_t'(err));
		apb_read(ADDR_OUT, rd, err);
		check_equal("OUT", apb_data_t'(out_m), rd);
		apb_read(ADDR_DIR, rd, err);
		check_equal("DIR", apb_data_t'(dir_m), rd);
		apb_read(ADDR_FSEL, rd, err);
		check_equal("FSEL", apb_data_t'(fsel_m), rd);
		finish_test();

		$display("%0d tests, %0d checks, %0d failures", test_cnt, check_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
